/* lsu_macros.svh */
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// Scratch memory geometry, banks interleaved on word address
`define LSU_NUM_BANKS 4
`define LSU_BANK_WORDS 64

// Request id tag
`define LSU_ID_W 4

// Derived address field widths
`define LSU_BANK_SEL_W ($clog2(`LSU_NUM_BANKS))
`define LSU_WORD_IDX_W ($clog2(`LSU_BANK_WORDS))

// Bits above the scratch range, must be zero for a legal access
`define LSU_ADDR_UPPER_W (32 - `LSU_WORD_IDX_W - `LSU_BANK_SEL_W - 2)

`endif

/* lsu_pkg.sv */
`default_nettype none

`include "lsu_macros.svh"

package lsu_pkg;

    ////////////////////
    // Function codes

    // RV32 load/store funct3, bit 2 marks unsigned loads
    typedef enum logic [2:0] {
        FN3_B  = 3'b000,
        FN3_H  = 3'b001,
        FN3_W  = 3'b010,
        FN3_BU = 3'b100,
        FN3_HU = 3'b101
    } ls_fn3_t;

    ////////////////////
    // Response status

    typedef enum logic [1:0] {
        EXC_NONE         = 2'd0,
        EXC_LD_MISALIGN  = 2'd1,
        EXC_ST_MISALIGN  = 2'd2,
        EXC_ACCESS_FAULT = 2'd3
    } ls_exc_t;

    ////////////////////
    // Address decode

    // Consecutive words land in consecutive banks
    typedef struct packed {
        logic [`LSU_ADDR_UPPER_W-1:0] upper;
        logic [`LSU_WORD_IDX_W-1:0]   word;
        logic [`LSU_BANK_SEL_W-1:0]   bank;
        logic [1:0]                   byte_off;
    } ls_addr_fields_t;

    typedef union packed {
        logic [31:0]     raw;
        ls_addr_fields_t f;
    } ls_addr_u;

endpackage

`default_nettype wire

/* lsu_issue.sv */
`default_nettype none

`include "lsu_macros.svh"

module lsu_issue
    import lsu_pkg::*;
(
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          req_valid,
    input  wire logic                          req_load,
    input  wire ls_fn3_t                       req_fn3,
    input  wire logic [31:0]                   req_base,
    input  wire logic [11:0]                   req_offset,
    input  wire logic [31:0]                   req_wdata,
    input  wire logic [`LSU_ID_W-1:0]          req_id,
    input  wire logic                          advance,
    output logic                               req_ready,
    output logic [`LSU_NUM_BANKS-1:0]          bank_en,
    output logic                               bank_we,
    output logic [3:0]                         bank_be,
    output logic [`LSU_WORD_IDX_W-1:0]         bank_word,
    output logic [31:0]                        bank_wdata,
    output logic                               s1_valid,
    output logic                               s1_load,
    output ls_fn3_t                            s1_fn3,
    output logic [1:0]                         s1_byte,
    output logic [`LSU_BANK_SEL_W-1:0]         s1_bank,
    output logic [`LSU_ID_W-1:0]               s1_id,
    output ls_exc_t                            s1_exc,
    output logic [31:0]                        s1_addr
);

    ls_addr_u addr;
    logic     accept;
    logic     misaligned;
    ls_exc_t  exc;
    logic     access_ok;

    ////////////////////
    // Address generation

    assign addr.raw = req_base + {{20{req_offset[11]}}, req_offset};

    always_comb begin
        case (req_fn3)
            FN3_H, FN3_HU: misaligned = addr.raw[0];
            FN3_W:         misaligned = |addr.raw[1:0];
            default:       misaligned = 1'b0;
        endcase
    end

    // Misalignment reported ahead of a range fault
    always_comb begin
        if (misaligned) begin
            exc = req_load ? EXC_LD_MISALIGN : EXC_ST_MISALIGN;
        end else if (|addr.f.upper) begin
            exc = EXC_ACCESS_FAULT;
        end else begin
            exc = EXC_NONE;
        end
    end

    assign req_ready = advance;
    assign accept    = req_valid && advance;
    assign access_ok = accept && (exc == EXC_NONE);

    ////////////////////
    // Bank side

    for (genvar i = 0; i < `LSU_NUM_BANKS; i++) begin : g_bank_sel
        assign bank_en[i] = access_ok && (addr.f.bank == i);
    end

    assign bank_we   = access_ok && !req_load;
    assign bank_word = addr.f.word;

    // Store lanes follow the low two fn3 bits
    always_comb begin
        case (req_fn3[1:0])
            2'b00: begin
                bank_be    = 4'b0001 << addr.f.byte_off;
                bank_wdata = {4{req_wdata[7:0]}};
            end
            2'b01: begin
                bank_be    = 4'b0011 << {addr.f.byte_off[1], 1'b0};
                bank_wdata = {2{req_wdata[15:0]}};
            end
            default: begin
                bank_be    = 4'b1111;
                bank_wdata = req_wdata;
            end
        endcase
    end

    ////////////////////
    // Attribute stage, moves with the bank read register

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            s1_load <= req_load;
            s1_fn3  <= req_fn3;
            s1_byte <= addr.f.byte_off;
            s1_bank <= addr.f.bank;
            s1_id   <= req_id;
            s1_exc  <= exc;
            s1_addr <= addr.raw;
        end
    end

endmodule

`default_nettype wire

/* data_bank.sv */
`default_nettype none

module data_bank #(
    parameter int WORDS = 64
) (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     en,
    input  wire logic                     we,
    input  wire logic [3:0]               be,
    input  wire logic [$clog2(WORDS)-1:0] word,
    input  wire logic [31:0]              wdata,
    input  wire logic                     advance,
    output logic [31:0]                   rdata
);

    logic [31:0] mem [WORDS];

    ////////////////////
    // Byte lane writes

    always_ff @(posedge clk) begin
        if (en && we) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    mem[word][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    ////////////////////
    // Read register

    // Holds while the response side is stalled
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata <= '0;
        end else if (advance && en && !we) begin
            rdata <= mem[word];
        end
    end

endmodule

`default_nettype wire

/* lsu_load_return.sv */
`default_nettype none

`include "lsu_macros.svh"

module lsu_load_return
    import lsu_pkg::*;
(
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic [31:0]                   bank_rdata [`LSU_NUM_BANKS],
    input  wire logic                          s1_valid,
    input  wire logic                          s1_load,
    input  wire ls_fn3_t                       s1_fn3,
    input  wire logic [1:0]                    s1_byte,
    input  wire logic [`LSU_BANK_SEL_W-1:0]    s1_bank,
    input  wire logic [`LSU_ID_W-1:0]          s1_id,
    input  wire ls_exc_t                       s1_exc,
    input  wire logic [31:0]                   s1_addr,
    input  wire logic                          rsp_ready,
    output logic                               advance,
    output logic                               rsp_valid,
    output logic [31:0]                        rsp_data,
    output logic [`LSU_ID_W-1:0]               rsp_id,
    output logic                               rsp_store,
    output ls_exc_t                            rsp_exc,
    output logic [31:0]                        rsp_addr
);

    logic [31:0] word;
    logic [15:0] half;
    logic [7:0]  lane;
    logic [31:0] load_data;

    ////////////////////
    // Lane alignment

    assign word = bank_rdata[s1_bank];
    // Halfword first, then byte within it
    assign half = s1_byte[1] ? word[31:16] : word[15:0];
    assign lane = s1_byte[0] ? half[15:8] : half[7:0];

    always_comb begin
        case (s1_fn3)
            FN3_B:   load_data = {{24{lane[7]}}, lane};
            FN3_H:   load_data = {{16{half[15]}}, half};
            FN3_BU:  load_data = {24'd0, lane};
            FN3_HU:  load_data = {16'd0, half};
            default: load_data = word;
        endcase
    end

    ////////////////////
    // Response register

    assign advance = !rsp_valid || rsp_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else if (advance) begin
            rsp_valid <= s1_valid;
        end
    end

    // Only clean loads carry data
    always_ff @(posedge clk) begin
        if (advance) begin
            rsp_data  <= (s1_load && s1_exc == EXC_NONE) ? load_data : '0;
            rsp_id    <= s1_id;
            rsp_store <= !s1_load;
            rsp_exc   <= s1_exc;
            rsp_addr  <= s1_addr;
        end
    end

endmodule

`default_nettype wire

/* lsu_top.sv */
`default_nettype none

`include "lsu_macros.svh"

module lsu_top
    import lsu_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 req_valid,
    output logic                      req_ready,
    input  wire logic                 req_load,
    input  wire ls_fn3_t              req_fn3,
    input  wire logic [31:0]          req_base,
    input  wire logic [11:0]          req_offset,
    input  wire logic [31:0]          req_wdata,
    input  wire logic [`LSU_ID_W-1:0] req_id,
    output logic                      rsp_valid,
    input  wire logic                 rsp_ready,
    output logic [31:0]               rsp_data,
    output logic [`LSU_ID_W-1:0]      rsp_id,
    output logic                      rsp_store,
    output ls_exc_t                   rsp_exc,
    output logic [31:0]               rsp_addr
);

    logic                         advance;
    logic [`LSU_NUM_BANKS-1:0]    bank_en;
    logic                         bank_we;
    logic [3:0]                   bank_be;
    logic [`LSU_WORD_IDX_W-1:0]   bank_word;
    logic [31:0]                  bank_wdata;
    logic [31:0]                  bank_rdata [`LSU_NUM_BANKS];

    logic                         s1_valid;
    logic                         s1_load;
    ls_fn3_t                      s1_fn3;
    logic [1:0]                   s1_byte;
    logic [`LSU_BANK_SEL_W-1:0]   s1_bank;
    logic [`LSU_ID_W-1:0]         s1_id;
    ls_exc_t                      s1_exc;
    logic [31:0]                  s1_addr;

    lsu_issue issue (.*);

    ////////////////////
    // Scratch banks

    for (genvar i = 0; i < `LSU_NUM_BANKS; i++) begin : bank
        data_bank #(
            .WORDS(`LSU_BANK_WORDS)
        ) mem_bank (
            .clk,
            .rst,
            .en      (bank_en[i]),
            .we      (bank_we),
            .be      (bank_be),
            .word    (bank_word),
            .wdata   (bank_wdata),
            .advance,
            .rdata   (bank_rdata[i])
        );
    end

    lsu_load_return ret (.*);

endmodule

`default_nettype wire

/* tb_lsu.sv */
`default_nettype none

`include "lsu_macros.svh"

module tb_lsu
    import lsu_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int SCRATCH_BYTES = `LSU_NUM_BANKS * `LSU_BANK_WORDS * 4;
    localparam int N_INIT        = 32;
    localparam int N_SWEEP       = 20;
    localparam int N_RAND        = 300;
    // Random ops may add one check load each
    localparam int CYCLE_LIMIT   = 4 * (N_INIT + N_SWEEP + 2 * N_RAND) + 100;

    typedef struct packed {
        logic [31:0]          data;
        logic [`LSU_ID_W-1:0] id;
        logic                 store;
        ls_exc_t              exc;
        logic [31:0]          addr;
    } exp_t;

    logic                 clk;
    logic                 rst;
    logic                 req_valid;
    logic                 req_ready;
    logic                 req_load;
    ls_fn3_t              req_fn3;
    logic [31:0]          req_base;
    logic [11:0]          req_offset;
    logic [31:0]          req_wdata;
    logic [`LSU_ID_W-1:0] req_id;
    logic                 rsp_valid;
    logic                 rsp_ready;
    logic [31:0]          rsp_data;
    logic [`LSU_ID_W-1:0] rsp_id;
    logic                 rsp_store;
    ls_exc_t              rsp_exc;
    logic [31:0]          rsp_addr;

    int      seed       = 32'h623e_a247;
    // Ready pattern has a stream of its own
    int      ready_seed = 32'h623e_a247;
    logic    hold_ready;
    int      value_errs;
    int      other_errs;
    int      rsp_count;
    logic    stall_seen;
    logic [31:0]          held_data;
    logic [`LSU_ID_W-1:0] held_id;
    // Address the current request is aimed at
    logic [31:0]          req_target;
    logic [7:0] ref_mem [SCRATCH_BYTES];
    exp_t       exp_q [$];
    ls_fn3_t    load_fns [5] = '{FN3_B, FN3_H, FN3_W, FN3_BU, FN3_HU};
    ls_fn3_t    mis_fns [3]  = '{FN3_H, FN3_W, FN3_HU};

    lsu_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////
    // Helpers

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % $unsigned(n));
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        value_errs++;
        $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    endtask

    // Little-endian bytes from the reference memory extended by fn3
    function automatic logic [31:0] read_ref(input logic [31:0] a, input ls_fn3_t fn3);
        logic [7:0] b0;
        logic [7:0] b1;
        b0 = ref_mem[a];
        b1 = ref_mem[a + 1];
        case (fn3)
            FN3_B:   return {{24{b0[7]}}, b0};
            FN3_BU:  return {24'd0, b0};
            FN3_H:   return {{16{b1[7]}}, b1, b0};
            FN3_HU:  return {16'd0, b1, b0};
            default: return {ref_mem[a + 3], ref_mem[a + 2], b1, b0};
        endcase
    endfunction

    task automatic write_ref(input logic [31:0] a, input ls_fn3_t fn3, input logic [31:0] d);
        int n;
        n = (fn3 == FN3_B) ? 1 : (fn3 == FN3_H) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            ref_mem[a + i] = d[8*i +: 8];
        end
    endtask

    // Expected response of the request accepted at this edge
    task automatic model_accept();
        logic [31:0] a;
        logic        mis;
        exp_t        e;
        a   = req_target;
        mis = ((req_fn3 == FN3_H || req_fn3 == FN3_HU) && a[0]) ||
              (req_fn3 == FN3_W && a[1:0] != 2'b00);
        e.id    = req_id;
        e.store = !req_load;
        e.addr  = a;
        e.data  = '0;
        if (mis) begin
            e.exc = req_load ? EXC_LD_MISALIGN : EXC_ST_MISALIGN;
        end else if (a >= SCRATCH_BYTES) begin
            e.exc = EXC_ACCESS_FAULT;
        end else begin
            e.exc = EXC_NONE;
            if (req_load) begin
                e.data = read_ref(a, req_fn3);
            end else begin
                write_ref(a, req_fn3, req_wdata);
            end
        end
        exp_q.push_back(e);
    endtask

    task automatic send_req(input logic load, input ls_fn3_t fn3, input logic [31:0] target,
                            input logic [31:0] wdata);
        logic [11:0] off;
        off        = 12'($random(seed));
        req_valid  = 1'b1;
        req_load   = load;
        req_fn3    = fn3;
        req_offset = off;
        req_base   = target - {{20{off[11]}}, off};
        req_wdata  = wdata;
        req_target = target;
        @(posedge clk);
        while (!req_ready) begin
            @(posedge clk);
        end
        #10;
        req_id = req_id + 1'b1;
    endtask

    ////////////////////
    // Checking

    always @(posedge clk) begin : monitor
        exp_t e;
        if (rst) begin
            stall_seen = 1'b0;
        end else begin
            if (stall_seen) begin
                assert (rsp_valid) else report_mismatch("rsp_valid", 32'd1, 32'(rsp_valid));
                assert (rsp_data == held_data)
                    else report_mismatch("rsp_data", held_data, rsp_data);
                assert (rsp_id == held_id)
                    else report_mismatch("rsp_id", 32'(held_id), 32'(rsp_id));
            end
            stall_seen = rsp_valid && !rsp_ready;
            held_data  = rsp_data;
            held_id    = rsp_id;
            if (rsp_valid && rsp_ready) begin
                if (exp_q.size() == 0) begin
                    other_errs++;
                    $display("Response at %0t ns with no request outstanding", $time);
                end else begin
                    e = exp_q.pop_front();
                    rsp_count++;
                    assert (rsp_id == e.id)
                        else report_mismatch("rsp_id", 32'(e.id), 32'(rsp_id));
                    assert (rsp_store == e.store)
                        else report_mismatch("rsp_store", 32'(e.store), 32'(rsp_store));
                    assert (rsp_exc == e.exc)
                        else report_mismatch("rsp_exc", 32'(e.exc), 32'(rsp_exc));
                    assert (rsp_addr == e.addr)
                        else report_mismatch("rsp_addr", e.addr, rsp_addr);
                    assert (rsp_data == e.data)
                        else report_mismatch("rsp_data", e.data, rsp_data);
                end
            end
            if (req_valid && req_ready) begin
                model_accept();
            end
        end
    end

    a_stall_blocks_req: assert property (@(posedge clk) disable iff (rst)
        (rsp_valid && !rsp_ready) |-> !req_ready)
        else report_mismatch("req_ready", 32'd0, 32'($sampled(req_ready)));

    // Held ready means a request can go every cycle
    a_ready_passes: assert property (@(posedge clk) disable iff (rst)
        rsp_ready |-> req_ready)
        else report_mismatch("req_ready", 32'd1, 32'($sampled(req_ready)));

    a_one_cycle_latency: assert property (@(posedge clk) disable iff (rst)
        (req_valid && req_ready) ##1 req_ready |=> rsp_valid)
        else report_mismatch("rsp_valid", 32'd1, 32'($sampled(rsp_valid)));

    always @(posedge clk) begin
        #10;
        rsp_ready = hold_ready || (($random(ready_seed) & 3) != 0);
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Something failed");
        $finish;
    end

    ////////////////////
    // Stimulus

    initial begin
        int          kind;
        logic        load;
        ls_fn3_t     fn;
        logic [31:0] target;
        rst        = 1'b1;
        req_valid  = 1'b0;
        req_load   = 1'b0;
        req_fn3    = FN3_W;
        req_base   = '0;
        req_offset = '0;
        req_wdata  = '0;
        req_id     = '0;
        req_target = '0;
        rsp_ready  = 1'b1;
        hold_ready = 1'b1;
        value_errs = 0;
        other_errs = 0;
        rsp_count  = 0;
        repeat (4) @(posedge clk);
        #10;
        rst = 1'b0;
        assert (rsp_valid == 1'b0) else report_mismatch("rsp_valid", 32'd0, 32'(rsp_valid));
        assert (req_ready == 1'b1) else report_mismatch("req_ready", 32'd1, 32'(req_ready));

        // Fill the test window back to back over every bank
        for (int i = 0; i < N_INIT; i++) begin
            send_req(1'b0, FN3_W, 32'(i * 4), $random(seed));
        end
        for (int i = 0; i < N_SWEEP; i++) begin
            send_req(1'b1, load_fns[i % 5], 32'(i * 4), 32'd0);
        end

        hold_ready = 1'b0;
        for (int n = 0; n < N_RAND; n++) begin
            kind = rand_below(8);
            load = 1'(rand_below(2));
            if (kind == 0) begin
                // Nonzero upper bits whose low bits alias into the test window
                target = ($random(seed) | 32'h400) & 32'hffff_fc7c;
                fn     = load ? load_fns[rand_below(5)] : load_fns[rand_below(3)];
                send_req(load, fn, target, $random(seed));
                send_req(1'b1, FN3_W, target & 32'h7c, 32'd0);
            end else if (kind == 1) begin
                fn     = load ? mis_fns[rand_below(3)] : mis_fns[rand_below(2)];
                target = 32'(rand_below(128));
                if (fn == FN3_W) begin
                    target[1:0] = 2'(1 + rand_below(3));
                end else begin
                    target[0] = 1'b1;
                end
                send_req(load, fn, target, $random(seed));
                send_req(1'b1, FN3_W, target & 32'h7c, 32'd0);
            end else begin
                fn     = load ? load_fns[rand_below(5)] : load_fns[rand_below(3)];
                target = 32'(rand_below(128));
                if (fn == FN3_W) begin
                    target[1:0] = 2'b00;
                end else if (fn == FN3_H || fn == FN3_HU) begin
                    target[0] = 1'b0;
                end
                send_req(load, fn, target, $random(seed));
            end
        end

        req_valid  = 1'b0;
        hold_ready = 1'b1;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        $display("Responses checked: %0d, value errors: %0d, other errors: %0d",
                 rsp_count, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+.
lsu_pkg.sv
lsu_issue.sv
data_bank.sv
lsu_load_return.sv
lsu_top.sv
tb_lsu.sv

/* Bender.yml */
package:
  name: lsu

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - lsu_pkg.sv
      - lsu_issue.sv
      - data_bank.sv
      - lsu_load_return.sv
      - lsu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_lsu.sv
